// File: Makefile
TOP = decode_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/decode_pkg.sv
package decode_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  reg_idx_t;

	// operation class handed to the execute stage
	typedef enum logic [4:0] {
		ALU_R_TYPE,
		ALU_ROTR,
		ALU_ROTRV,
		ALU_ADDI,
		ALU_ADDIU,
		ALU_SLTI,
		ALU_SLTIU,
		ALU_ANDI,
		ALU_ORI,
		ALU_XORI,
		ALU_LUI,
		ALU_MEM,
		ALU_MTC0,
		ALU_MFC0,
		ALU_MUL,
		ALU_MADD,
		ALU_MADDU,
		ALU_MSUB,
		ALU_MSUBU,
		ALU_NONE
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LEZ  = 3'd3,
		BR_GTZ  = 3'd4,
		BR_LTZ  = 3'd5,
		BR_GEZ  = 3'd6
	} branch_cond_e;

	// field positions in the instruction word
	localparam int OP_MSB    = 31;
	localparam int OP_LSB    = 26;
	localparam int RS_MSB    = 25;
	localparam int RS_LSB    = 21;
	localparam int RT_MSB    = 20;
	localparam int RT_LSB    = 16;
	localparam int FN_MSB    = 5;
	localparam int FN_LSB    = 0;
	localparam int ROTR_BIT  = 21;
	localparam int ROTRV_BIT = 6;

	// major opcodes
	localparam opcode_t OP_R_TYPE   = 6'b000000;
	localparam opcode_t OP_REGIMM   = 6'b000001;
	localparam opcode_t OP_J        = 6'b000010;
	localparam opcode_t OP_JAL      = 6'b000011;
	localparam opcode_t OP_BEQ      = 6'b000100;
	localparam opcode_t OP_BNE      = 6'b000101;
	localparam opcode_t OP_BLEZ     = 6'b000110;
	localparam opcode_t OP_BGTZ     = 6'b000111;
	localparam opcode_t OP_ADDI     = 6'b001000;
	localparam opcode_t OP_ADDIU    = 6'b001001;
	localparam opcode_t OP_SLTI     = 6'b001010;
	localparam opcode_t OP_SLTIU    = 6'b001011;
	localparam opcode_t OP_ANDI     = 6'b001100;
	localparam opcode_t OP_ORI      = 6'b001101;
	localparam opcode_t OP_XORI     = 6'b001110;
	localparam opcode_t OP_LUI      = 6'b001111;
	localparam opcode_t OP_COP0     = 6'b010000;
	localparam opcode_t OP_SPECIAL2 = 6'b011100;
	localparam opcode_t OP_LB       = 6'b100000;
	localparam opcode_t OP_LH       = 6'b100001;
	localparam opcode_t OP_LWL      = 6'b100010;
	localparam opcode_t OP_LW       = 6'b100011;
	localparam opcode_t OP_LBU      = 6'b100100;
	localparam opcode_t OP_LHU      = 6'b100101;
	localparam opcode_t OP_LWR      = 6'b100110;
	localparam opcode_t OP_SB       = 6'b101000;
	localparam opcode_t OP_SH       = 6'b101001;
	localparam opcode_t OP_SWL      = 6'b101010;
	localparam opcode_t OP_SW       = 6'b101011;
	localparam opcode_t OP_SWR      = 6'b101110;
	localparam opcode_t OP_LL       = 6'b110000;

	// top opcode nibble of the zero-extending immediates
	localparam logic [3:0] OP_LOGIC_IMM_HI = 4'b0011;

	// R-type funct
	localparam funct_t FN_SLL     = 6'b000000;
	localparam funct_t FN_SRL     = 6'b000010;
	localparam funct_t FN_SRA     = 6'b000011;
	localparam funct_t FN_SLLV    = 6'b000100;
	localparam funct_t FN_SRLV    = 6'b000110;
	localparam funct_t FN_SRAV    = 6'b000111;
	localparam funct_t FN_JR      = 6'b001000;
	localparam funct_t FN_JALR    = 6'b001001;
	localparam funct_t FN_MOVZ    = 6'b001010;
	localparam funct_t FN_MOVN    = 6'b001011;
	localparam funct_t FN_SYSCALL = 6'b001100;
	localparam funct_t FN_BREAK   = 6'b001101;
	localparam funct_t FN_MFHI    = 6'b010000;
	localparam funct_t FN_MTHI    = 6'b010001;
	localparam funct_t FN_MFLO    = 6'b010010;
	localparam funct_t FN_MTLO    = 6'b010011;
	localparam funct_t FN_MULT    = 6'b011000;
	localparam funct_t FN_MULTU   = 6'b011001;
	localparam funct_t FN_DIV     = 6'b011010;
	localparam funct_t FN_DIVU    = 6'b011011;
	localparam funct_t FN_ADD     = 6'b100000;
	localparam funct_t FN_ADDU    = 6'b100001;
	localparam funct_t FN_SUB     = 6'b100010;
	localparam funct_t FN_SUBU    = 6'b100011;
	localparam funct_t FN_AND     = 6'b100100;
	localparam funct_t FN_OR      = 6'b100101;
	localparam funct_t FN_XOR     = 6'b100110;
	localparam funct_t FN_NOR     = 6'b100111;
	localparam funct_t FN_SLT     = 6'b101010;
	localparam funct_t FN_SLTU    = 6'b101011;

	// SPECIAL2 funct
	localparam funct_t FN_MADD  = 6'b000000;
	localparam funct_t FN_MADDU = 6'b000001;
	localparam funct_t FN_MUL   = 6'b000010;
	localparam funct_t FN_MSUB  = 6'b000100;
	localparam funct_t FN_MSUBU = 6'b000101;

	// REGIMM selectors in rt
	localparam reg_idx_t RT_BLTZ   = 5'b00000;
	localparam reg_idx_t RT_BGEZ   = 5'b00001;
	localparam reg_idx_t RT_BLTZAL = 5'b10000;
	localparam reg_idx_t RT_BGEZAL = 5'b10001;

	// COP0 selectors in rs
	localparam reg_idx_t RS_MFC0 = 5'b00000;
	localparam reg_idx_t RS_MTC0 = 5'b00100;
	localparam reg_idx_t RS_CO   = 5'b10000;

	localparam funct_t FN_ERET = 6'b011000;
	localparam logic [25:0] ERET_WORD = {RS_CO, 15'd0, FN_ERET};

endpackage

// File: decoder/main_ctrl_dec.sv
`timescale 1ns/100ps

module main_ctrl_dec (
	input  decode_pkg::opcode_t  opcode,
	input  decode_pkg::funct_t   funct,
	input  decode_pkg::reg_idx_t rs,
	input  decode_pkg::reg_idx_t rt,
	input  decode_pkg::instr_t   instr,
	output decode_pkg::alu_op_e  alu_op,
	output logic                 reg_write,
	output logic                 reg_dst,
	output logic                 is_imm,
	output logic                 mem_to_reg,
	output logic                 mem_read,
	output logic                 mem_write,
	output logic                 is_mfc,
	output logic                 ri,
	output logic                 single_issue
);

	function automatic decode_pkg::alu_op_e imm_op(input decode_pkg::opcode_t op);
		case (op)
			decode_pkg::OP_ADDI:  imm_op = decode_pkg::ALU_ADDI;
			decode_pkg::OP_ADDIU: imm_op = decode_pkg::ALU_ADDIU;
			decode_pkg::OP_SLTI:  imm_op = decode_pkg::ALU_SLTI;
			decode_pkg::OP_SLTIU: imm_op = decode_pkg::ALU_SLTIU;
			decode_pkg::OP_ANDI:  imm_op = decode_pkg::ALU_ANDI;
			decode_pkg::OP_ORI:   imm_op = decode_pkg::ALU_ORI;
			decode_pkg::OP_XORI:  imm_op = decode_pkg::ALU_XORI;
			decode_pkg::OP_LUI:   imm_op = decode_pkg::ALU_LUI;
			default:              imm_op = decode_pkg::ALU_NONE;
		endcase
	endfunction

	always_comb begin
		alu_op = decode_pkg::ALU_NONE;
		reg_write = 1'b0;
		reg_dst = 1'b0;
		is_imm = 1'b0;
		mem_to_reg = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_mfc = 1'b0;
		ri = 1'b0;
		single_issue = 1'b0;
		case (opcode)
			decode_pkg::OP_R_TYPE: begin
				case (funct)
					decode_pkg::FN_ADD, decode_pkg::FN_ADDU, decode_pkg::FN_SUB,
					decode_pkg::FN_SUBU, decode_pkg::FN_SLT, decode_pkg::FN_SLTU,
					decode_pkg::FN_AND, decode_pkg::FN_OR, decode_pkg::FN_XOR,
					decode_pkg::FN_NOR, decode_pkg::FN_SLL, decode_pkg::FN_SLLV,
					decode_pkg::FN_SRA, decode_pkg::FN_SRAV, decode_pkg::FN_MOVN,
					decode_pkg::FN_MOVZ, decode_pkg::FN_MFHI, decode_pkg::FN_MFLO: begin
						alu_op = decode_pkg::ALU_R_TYPE;
						reg_write = 1'b1;
					end
					// bit 21 turns SRL into ROTR
					decode_pkg::FN_SRL: begin
						alu_op = instr[decode_pkg::ROTR_BIT] ? decode_pkg::ALU_ROTR
							: decode_pkg::ALU_R_TYPE;
						reg_write = 1'b1;
					end
					decode_pkg::FN_SRLV: begin
						alu_op = instr[decode_pkg::ROTRV_BIT] ? decode_pkg::ALU_ROTRV
							: decode_pkg::ALU_R_TYPE;
						reg_write = 1'b1;
					end
					// no register file write
					decode_pkg::FN_JR, decode_pkg::FN_MULT, decode_pkg::FN_MULTU,
					decode_pkg::FN_DIV, decode_pkg::FN_DIVU, decode_pkg::FN_MTHI,
					decode_pkg::FN_MTLO, decode_pkg::FN_SYSCALL, decode_pkg::FN_BREAK: begin
						alu_op = decode_pkg::ALU_R_TYPE;
					end
					decode_pkg::FN_JALR: begin
						alu_op = decode_pkg::ALU_R_TYPE;
						reg_write = 1'b1;
						reg_dst = 1'b1;
					end
					// unknown funct still claims a write
					default: begin
						ri = 1'b1;
						reg_write = 1'b1;
					end
				endcase
			end
			decode_pkg::OP_ADDI, decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI,
			decode_pkg::OP_SLTIU, decode_pkg::OP_ANDI, decode_pkg::OP_ORI,
			decode_pkg::OP_XORI, decode_pkg::OP_LUI: begin
				alu_op = imm_op(opcode);
				reg_write = 1'b1;
				is_imm = 1'b1;
			end
			// plain branches and J touch neither registers nor memory
			decode_pkg::OP_BEQ, decode_pkg::OP_BNE, decode_pkg::OP_BLEZ,
			decode_pkg::OP_BGTZ, decode_pkg::OP_J: begin
				alu_op = decode_pkg::ALU_NONE;
			end
			decode_pkg::OP_REGIMM: begin
				case (rt)
					decode_pkg::RT_BGEZAL, decode_pkg::RT_BLTZAL: begin
						reg_write = 1'b1;
						reg_dst = 1'b1;
					end
					decode_pkg::RT_BGEZ, decode_pkg::RT_BLTZ: begin
						alu_op = decode_pkg::ALU_NONE;
					end
					default: begin
						ri = 1'b1;
					end
				endcase
			end
			// link to r31
			decode_pkg::OP_JAL: begin
				reg_write = 1'b1;
				reg_dst = 1'b1;
			end
			decode_pkg::OP_LB, decode_pkg::OP_LBU, decode_pkg::OP_LH, decode_pkg::OP_LHU,
			decode_pkg::OP_LW, decode_pkg::OP_LWL, decode_pkg::OP_LWR, decode_pkg::OP_LL: begin
				alu_op = decode_pkg::ALU_MEM;
				reg_write = 1'b1;
				is_imm = 1'b1;
				mem_to_reg = 1'b1;
				mem_read = 1'b1;
				single_issue = 1'b1;
			end
			decode_pkg::OP_SB, decode_pkg::OP_SH, decode_pkg::OP_SW,
			decode_pkg::OP_SWL, decode_pkg::OP_SWR: begin
				alu_op = decode_pkg::ALU_MEM;
				is_imm = 1'b1;
				mem_write = 1'b1;
				single_issue = 1'b1;
			end
			decode_pkg::OP_COP0: begin
				single_issue = 1'b1;
				case (rs)
					decode_pkg::RS_MTC0: begin
						alu_op = decode_pkg::ALU_MTC0;
					end
					decode_pkg::RS_MFC0: begin
						alu_op = decode_pkg::ALU_MFC0;
						reg_write = 1'b1;
						is_mfc = 1'b1;
					end
					// only an exact ERET word is legal here
					default: begin
						ri = instr[decode_pkg::RS_MSB:0] != decode_pkg::ERET_WORD;
					end
				endcase
			end
			decode_pkg::OP_SPECIAL2: begin
				case (funct)
					decode_pkg::FN_MUL: begin
						alu_op = decode_pkg::ALU_MUL;
						reg_write = 1'b1;
					end
					decode_pkg::FN_MADD:  alu_op = decode_pkg::ALU_MADD;
					decode_pkg::FN_MADDU: alu_op = decode_pkg::ALU_MADDU;
					decode_pkg::FN_MSUB:  alu_op = decode_pkg::ALU_MSUB;
					decode_pkg::FN_MSUBU: alu_op = decode_pkg::ALU_MSUBU;
					default: begin
						ri = 1'b1;
					end
				endcase
			end
			default: begin
				ri = 1'b1;
			end
		endcase
	end

endmodule

// File: decoder/operand_use_dec.sv
`timescale 1ns/100ps

module operand_use_dec (
	input  decode_pkg::opcode_t  opcode,
	input  decode_pkg::funct_t   funct,
	input  decode_pkg::reg_idx_t rs,
	input  decode_pkg::reg_idx_t rt,
	output logic                 read_rs,
	output logic                 read_rt
);

	always_comb begin
		{read_rs, read_rt} = 2'b00;
		case (opcode)
			decode_pkg::OP_R_TYPE: begin
				case (funct)
					decode_pkg::FN_ADD, decode_pkg::FN_ADDU, decode_pkg::FN_SUB,
					decode_pkg::FN_SUBU, decode_pkg::FN_SLT, decode_pkg::FN_SLTU,
					decode_pkg::FN_AND, decode_pkg::FN_OR, decode_pkg::FN_XOR,
					decode_pkg::FN_NOR, decode_pkg::FN_SLLV, decode_pkg::FN_SRLV,
					decode_pkg::FN_SRAV, decode_pkg::FN_MOVN, decode_pkg::FN_MOVZ,
					decode_pkg::FN_MULT, decode_pkg::FN_MULTU, decode_pkg::FN_DIV,
					decode_pkg::FN_DIVU: begin
						{read_rs, read_rt} = 2'b11;
					end
					// shift amount comes from the word, not rs
					decode_pkg::FN_SLL, decode_pkg::FN_SRL, decode_pkg::FN_SRA: begin
						{read_rs, read_rt} = 2'b01;
					end
					decode_pkg::FN_JR, decode_pkg::FN_JALR, decode_pkg::FN_MTHI,
					decode_pkg::FN_MTLO: begin
						{read_rs, read_rt} = 2'b10;
					end
					default: begin
						{read_rs, read_rt} = 2'b00;
					end
				endcase
			end
			decode_pkg::OP_ADDI, decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI,
			decode_pkg::OP_SLTIU, decode_pkg::OP_ANDI, decode_pkg::OP_ORI,
			decode_pkg::OP_XORI, decode_pkg::OP_BLEZ, decode_pkg::OP_BGTZ,
			decode_pkg::OP_LB, decode_pkg::OP_LBU, decode_pkg::OP_LH, decode_pkg::OP_LHU,
			decode_pkg::OP_LW, decode_pkg::OP_LWL, decode_pkg::OP_LWR, decode_pkg::OP_LL: begin
				{read_rs, read_rt} = 2'b10;
			end
			// store data sits in rt
			decode_pkg::OP_BEQ, decode_pkg::OP_BNE, decode_pkg::OP_SB, decode_pkg::OP_SH,
			decode_pkg::OP_SW, decode_pkg::OP_SWL, decode_pkg::OP_SWR: begin
				{read_rs, read_rt} = 2'b11;
			end
			decode_pkg::OP_REGIMM: begin
				case (rt)
					decode_pkg::RT_BLTZ, decode_pkg::RT_BGEZ,
					decode_pkg::RT_BLTZAL, decode_pkg::RT_BGEZAL: begin
						{read_rs, read_rt} = 2'b10;
					end
					default: begin
						{read_rs, read_rt} = 2'b00;
					end
				endcase
			end
			decode_pkg::OP_COP0: begin
				read_rt = rs == decode_pkg::RS_MTC0;
			end
			decode_pkg::OP_SPECIAL2: begin
				case (funct)
					decode_pkg::FN_MUL, decode_pkg::FN_MADD, decode_pkg::FN_MADDU,
					decode_pkg::FN_MSUB, decode_pkg::FN_MSUBU: begin
						{read_rs, read_rt} = 2'b11;
					end
					default: begin
						{read_rs, read_rt} = 2'b00;
					end
				endcase
			end
			default: begin
				{read_rs, read_rt} = 2'b00;
			end
		endcase
	end

endmodule

// File: decoder/side_effect_dec.sv
`timescale 1ns/100ps

module side_effect_dec (
	input  decode_pkg::opcode_t      opcode,
	input  decode_pkg::funct_t       funct,
	input  decode_pkg::reg_idx_t     rs,
	input  decode_pkg::reg_idx_t     rt,
	output decode_pkg::branch_cond_e branch_cond,
	output logic                     hilo_read,
	output logic                     hilo_write,
	output logic                     muldiv_en,
	output logic                     cp0_read,
	output logic                     cp0_write,
	output logic                     eret,
	output logic                     syscall,
	output logic                     brk,
	output logic                     sign_ex
);

	logic is_special;
	logic is_cop0;

	assign is_special = opcode == decode_pkg::OP_R_TYPE;
	assign is_cop0 = opcode == decode_pkg::OP_COP0;

	always_comb begin
		case (opcode)
			decode_pkg::OP_BEQ:  branch_cond = decode_pkg::BR_EQ;
			decode_pkg::OP_BNE:  branch_cond = decode_pkg::BR_NE;
			decode_pkg::OP_BLEZ: branch_cond = decode_pkg::BR_LEZ;
			decode_pkg::OP_BGTZ: branch_cond = decode_pkg::BR_GTZ;
			// every other REGIMM selector falls back to LTZ
			decode_pkg::OP_REGIMM: begin
				if (rt == decode_pkg::RT_BGEZ || rt == decode_pkg::RT_BGEZAL)
					branch_cond = decode_pkg::BR_GEZ;
				else
					branch_cond = decode_pkg::BR_LTZ;
			end
			default: branch_cond = decode_pkg::BR_NONE;
		endcase
	end

	always_comb begin
		muldiv_en = 1'b0;
		hilo_read = 1'b0;
		hilo_write = 1'b0;
		case (opcode)
			decode_pkg::OP_R_TYPE: begin
				case (funct)
					decode_pkg::FN_MULT, decode_pkg::FN_MULTU,
					decode_pkg::FN_DIV, decode_pkg::FN_DIVU: muldiv_en = 1'b1;
					decode_pkg::FN_MFHI, decode_pkg::FN_MFLO: hilo_read = 1'b1;
					decode_pkg::FN_MTHI, decode_pkg::FN_MTLO: hilo_write = 1'b1;
					default: muldiv_en = 1'b0;
				endcase
			end
			decode_pkg::OP_SPECIAL2: begin
				case (funct)
					decode_pkg::FN_MUL: muldiv_en = 1'b1;
					// accumulate reads and rewrites HI/LO
					decode_pkg::FN_MADD, decode_pkg::FN_MADDU,
					decode_pkg::FN_MSUB, decode_pkg::FN_MSUBU: begin
						muldiv_en = 1'b1;
						hilo_read = 1'b1;
						hilo_write = 1'b1;
					end
					default: muldiv_en = 1'b0;
				endcase
			end
			default: muldiv_en = 1'b0;
		endcase
	end

	assign cp0_read = is_cop0 && rs == decode_pkg::RS_MFC0;
	assign cp0_write = is_cop0 && rs == decode_pkg::RS_MTC0;
	assign eret = is_cop0 && rs == decode_pkg::RS_CO && funct == decode_pkg::FN_ERET;
	assign syscall = is_special && funct == decode_pkg::FN_SYSCALL;
	assign brk = is_special && funct == decode_pkg::FN_BREAK;

	// ANDI, ORI, XORI and LUI zero-extend
	assign sign_ex = opcode[5:2] != decode_pkg::OP_LOGIC_IMM_HI;

endmodule

// File: list.f
common/decode_pkg.sv
decoder/main_ctrl_dec.sv
decoder/operand_use_dec.sv
decoder/side_effect_dec.sv
src/decode_stage.sv
tb/decode_stage_tb.sv

// File: src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  decode_pkg::instr_t       instr,
	output logic                     out_valid,
	input  logic                     out_ready,
	output decode_pkg::alu_op_e      alu_op,
	output logic                     reg_write,
	output logic                     reg_dst,
	output logic                     is_imm,
	output logic                     mem_to_reg,
	output logic                     mem_read,
	output logic                     mem_write,
	output logic                     is_mfc,
	output logic                     ri,
	output logic                     single_issue,
	output logic                     read_rs,
	output logic                     read_rt,
	output decode_pkg::branch_cond_e branch_cond,
	output logic                     hilo_read,
	output logic                     hilo_write,
	output logic                     muldiv_en,
	output logic                     cp0_read,
	output logic                     cp0_write,
	output logic                     eret,
	output logic                     syscall,
	output logic                     brk,
	output logic                     sign_ex
);

	decode_pkg::opcode_t      opcode;
	decode_pkg::funct_t       funct;
	decode_pkg::reg_idx_t     rs;
	decode_pkg::reg_idx_t     rt;
	decode_pkg::alu_op_e      d_alu_op;
	decode_pkg::branch_cond_e d_branch_cond;
	// flag bundles, msb first in port order
	logic [8:0]               d_main;
	logic [1:0]               d_use;
	logic [8:0]               d_side;

	assign opcode = instr[decode_pkg::OP_MSB:decode_pkg::OP_LSB];
	assign rs = instr[decode_pkg::RS_MSB:decode_pkg::RS_LSB];
	assign rt = instr[decode_pkg::RT_MSB:decode_pkg::RT_LSB];
	assign funct = instr[decode_pkg::FN_MSB:decode_pkg::FN_LSB];

	main_ctrl_dec u_main_ctrl_dec (
		.opcode       (opcode),
		.funct        (funct),
		.rs           (rs),
		.rt           (rt),
		.instr        (instr),
		.alu_op       (d_alu_op),
		.reg_write    (d_main[8]),
		.reg_dst      (d_main[7]),
		.is_imm       (d_main[6]),
		.mem_to_reg   (d_main[5]),
		.mem_read     (d_main[4]),
		.mem_write    (d_main[3]),
		.is_mfc       (d_main[2]),
		.ri           (d_main[1]),
		.single_issue (d_main[0])
	);

	operand_use_dec u_operand_use_dec (
		.opcode  (opcode),
		.funct   (funct),
		.rs      (rs),
		.rt      (rt),
		.read_rs (d_use[1]),
		.read_rt (d_use[0])
	);

	side_effect_dec u_side_effect_dec (
		.opcode      (opcode),
		.funct       (funct),
		.rs          (rs),
		.rt          (rt),
		.branch_cond (d_branch_cond),
		.hilo_read   (d_side[8]),
		.hilo_write  (d_side[7]),
		.muldiv_en   (d_side[6]),
		.cp0_read    (d_side[5]),
		.cp0_write   (d_side[4]),
		.eret        (d_side[3]),
		.syscall     (d_side[2]),
		.brk         (d_side[1]),
		.sign_ex     (d_side[0])
	);

	// free slot, or the held word leaves this cycle
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alu_op <= decode_pkg::ALU_NONE;
			branch_cond <= decode_pkg::BR_NONE;
			{reg_write, reg_dst, is_imm, mem_to_reg, mem_read, mem_write,
				is_mfc, ri, single_issue} <= '0;
			{read_rs, read_rt} <= '0;
			{hilo_read, hilo_write, muldiv_en, cp0_read, cp0_write,
				eret, syscall, brk, sign_ex} <= '0;
		end else if (in_valid && in_ready) begin
			alu_op <= d_alu_op;
			branch_cond <= d_branch_cond;
			{reg_write, reg_dst, is_imm, mem_to_reg, mem_read, mem_write,
				is_mfc, ri, single_issue} <= d_main;
			{read_rs, read_rt} <= d_use;
			{hilo_read, hilo_write, muldiv_en, cp0_read, cp0_write,
				eret, syscall, brk, sign_ex} <= d_side;
		end
	end

endmodule

// File: tb/decode_stage_tb.sv
`timescale 1ns/100ps

module decode_stage_tb;

	localparam int NUM_VEC = 41;
	localparam int COLS = 6;
	localparam int MAX_CYCLES = NUM_VEC * 20;

	logic                     clk;
	logic                     rst_n;
	logic                     in_valid;
	logic                     in_ready;
	decode_pkg::instr_t       instr;
	logic                     out_valid;
	logic                     out_ready;
	decode_pkg::alu_op_e      alu_op;
	decode_pkg::branch_cond_e branch_cond;
	logic                     reg_write;
	logic                     reg_dst;
	logic                     is_imm;
	logic                     mem_to_reg;
	logic                     mem_read;
	logic                     mem_write;
	logic                     is_mfc;
	logic                     ri;
	logic                     single_issue;
	logic                     read_rs;
	logic                     read_rt;
	logic                     hilo_read;
	logic                     hilo_write;
	logic                     muldiv_en;
	logic                     cp0_read;
	logic                     cp0_write;
	logic                     eret;
	logic                     syscall;
	logic                     brk;
	logic                     sign_ex;
	logic [8:0]               main_flags;
	logic [1:0]               use_flags;
	logic [8:0]               side_flags;

	logic [31:0] vec_mem [0:NUM_VEC*COLS-1];
	int          err_count;
	int          tests_run;
	int          tests_failed;

	assign main_flags = {reg_write, reg_dst, is_imm, mem_to_reg, mem_read, mem_write,
		is_mfc, ri, single_issue};
	assign use_flags = {read_rs, read_rt};
	assign side_flags = {hilo_read, hilo_write, muldiv_en, cp0_read, cp0_write,
		eret, syscall, brk, sign_ex};

	decode_stage u_decode_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.instr        (instr),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.alu_op       (alu_op),
		.reg_write    (reg_write),
		.reg_dst      (reg_dst),
		.is_imm       (is_imm),
		.mem_to_reg   (mem_to_reg),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.is_mfc       (is_mfc),
		.ri           (ri),
		.single_issue (single_issue),
		.read_rs      (read_rs),
		.read_rt      (read_rt),
		.branch_cond  (branch_cond),
		.hilo_read    (hilo_read),
		.hilo_write   (hilo_write),
		.muldiv_en    (muldiv_en),
		.cp0_read     (cp0_read),
		.cp0_write    (cp0_write),
		.eret         (eret),
		.syscall      (syscall),
		.brk          (brk),
		.sign_ex      (sign_ex)
	);

	always #4 clk = ~clk;

	task automatic alu_op_check(input decode_pkg::alu_op_e got, input decode_pkg::alu_op_e exp);
		if (got !== exp) begin
			$display("[FAIL] alu_op: got %h, expected %h", got, exp);
			err_count++;
		end
	endtask

	task automatic branch_cond_check(input decode_pkg::branch_cond_e got,
		input decode_pkg::branch_cond_e exp);
		if (got !== exp) begin
			$display("[FAIL] branch_cond: got %h, expected %h", got, exp);
			err_count++;
		end
	endtask

	task automatic main_flags_check(input logic [8:0] got, input logic [8:0] exp);
		if (got !== exp) begin
			$display("[FAIL] main_flags: got %h, expected %h", got, exp);
			err_count++;
		end
	endtask

	task automatic use_flags_check(input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] use_flags: got %h, expected %h", got, exp);
			err_count++;
		end
	endtask

	task automatic side_flags_check(input logic [8:0] got, input logic [8:0] exp);
		if (got !== exp) begin
			$display("[FAIL] side_flags: got %h, expected %h", got, exp);
			err_count++;
		end
	endtask

	task automatic plain_error(input string what);
		$display("error: %s", what);
		err_count++;
	endtask

	task automatic test_done(input string name, input bit failed);
		tests_run++;
		if (failed)
			tests_failed++;
		$display("%s: %s", name, failed ? "failed" : "passed");
	endtask

	// columns: instr, alu_op, branch_cond, main flags, use flags, side flags
	task automatic vector_check(input int idx);
		int b;
		b = idx * COLS;
		alu_op_check(alu_op, decode_pkg::alu_op_e'(vec_mem[b+1][4:0]));
		branch_cond_check(branch_cond, decode_pkg::branch_cond_e'(vec_mem[b+2][2:0]));
		main_flags_check(main_flags, vec_mem[b+3][8:0]);
		use_flags_check(use_flags, vec_mem[b+4][1:0]);
		side_flags_check(side_flags, vec_mem[b+5][8:0]);
	endtask

	task automatic reset_check();
		int mark;
		mark = err_count;
		if (out_valid !== 1'b0)
			plain_error("out_valid is not low after reset");
		if (in_ready !== 1'b1)
			plain_error("in_ready is not high after reset");
		alu_op_check(alu_op, decode_pkg::ALU_NONE);
		branch_cond_check(branch_cond, decode_pkg::BR_NONE);
		main_flags_check(main_flags, 9'h000);
		use_flags_check(use_flags, 2'b00);
		side_flags_check(side_flags, 9'h000);
		test_done("reset state", err_count != mark);
	endtask

	// drive on the falling edge, sample 1 ns later while the outputs are stable
	task automatic run_pass(input int pass_no, input bit stall);
		int next_idx;
		int taken;
		int head;
		int mark;
		bit accept;
		bit take;
		bit accepted_last;
		int exp_q[$];
		next_idx = 0;
		taken = 0;
		mark = err_count;
		accepted_last = 1'b0;
		while (taken < NUM_VEC) begin
			@(negedge clk);
			in_valid = next_idx < NUM_VEC;
			instr = in_valid ? vec_mem[next_idx*COLS] : 32'h0;
			out_ready = stall ? (($urandom % 4) != 0) : 1'b1;
			#1;
			if (accepted_last && !out_valid)
				plain_error("no result one cycle after acceptance");
			if (!stall && !in_ready)
				plain_error("in_ready dropped while out_ready was held high");
			if (out_valid) begin
				if (exp_q.size() == 0)
					plain_error("out_valid high with no instruction in flight");
				else
					vector_check(exp_q[0]);
			end
			accept = in_valid && in_ready;
			take = out_valid && out_ready;
			if (take && exp_q.size() > 0) begin
				head = exp_q.pop_front();
				taken++;
				test_done($sformatf("pass %0d vector %0d instr %h", pass_no, head,
					vec_mem[head*COLS]), err_count != mark);
				mark = err_count;
			end
			if (accept) begin
				exp_q.push_back(next_idx);
				next_idx++;
			end
			accepted_last = accept;
		end
	endtask

	initial begin
		repeat (MAX_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hf2cf6439));
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		instr = '0;
		out_ready = 1'b0;
		err_count = 0;
		tests_run = 0;
		tests_failed = 0;
		$readmemh("tb/decode_stimulus.txt", vec_mem);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		reset_check();
		// back to back, then with random stalls
		run_pass(1, 1'b0);
		run_pass(2, 1'b1);
		$display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed,
			err_count);
		if (tests_failed == 0 && err_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: tb/decode_stimulus.txt
// instr    alu br main use side
// main = reg_write..single_issue, use = read_rs,read_rt, side = hilo_read..sign_ex
00221820 00 0 100 3 001 // add
000220C0 00 0 100 1 001 // sll
000220C2 00 0 100 1 001 // srl
002220C2 01 0 100 1 001 // rotr
00622006 00 0 100 3 001 // srlv
00622046 02 0 100 3 001 // rotrv
03E00008 00 0 000 2 001 // jr
00A0F809 00 0 180 2 001 // jalr
00004010 00 0 100 0 101 // mfhi
01200013 00 0 000 2 081 // mtlo
00220018 00 0 000 3 041 // mult
0000000C 00 0 000 0 005 // syscall
0000000D 00 0 000 0 003 // break
20220005 03 0 140 2 001 // addi
2C830010 06 0 140 2 001 // sltiu
302200FF 07 0 140 2 000 // andi
34220001 08 0 140 2 000 // ori
38220002 09 0 140 2 000 // xori
3C051234 0A 0 140 0 000 // lui
8C220004 0B 0 171 2 001 // lw
AC220008 0B 0 049 3 001 // sw
10220004 13 1 000 3 001 // beq
14220004 13 2 000 3 001 // bne
18200004 13 3 000 2 001 // blez
1C200004 13 4 000 2 001 // bgtz
04200004 13 5 000 2 001 // bltz
04310004 13 6 180 2 001 // bgezal
08000100 13 0 000 0 001 // j
0C000100 13 0 180 0 001 // jal
40026000 0D 0 105 0 021 // mfc0
40826000 0C 0 001 1 011 // mtc0
42000018 13 0 001 0 009 // eret
42000019 13 0 003 0 001 // unknown cop0
70221802 0E 0 100 3 041 // mul
70220000 0F 0 000 3 1C1 // madd
70220005 12 0 000 3 1C1 // msubu
7C021420 13 0 002 0 001 // seb
70201021 13 0 002 0 001 // clo
00220034 13 0 102 0 001 // teq
042C0005 13 5 002 0 001 // teqi
FC000000 13 0 002 0 001 // undefined opcode
